// ==== dma_desc_top.f ====
src/dma_desc_pkg.sv
src/dma_mem_if.sv
src/dma_desc_if.sv
src/dma_desc_regs.sv
src/dma_desc_fetch.sv
src/dma_xfer_engine.sv
src/dma_mem_arbiter.sv
src/dma_desc_top.sv
verification/tb_mem_model.sv
verification/tb_dma_desc.sv

// ==== Makefile ====
# Verilator flow for the descriptor DMA
TOP = tb_dma_desc

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module dma_desc_top -f dma_desc_top.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f dma_desc_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_dma_desc.sv ====
/* Testbench for dma_desc_top with random descriptor chains and a word model of memory.
   Source, destination, decoy and descriptor regions never overlap */
`timescale 1ns/100ps

module tb_dma_desc import dma_desc_pkg::*; ();

  localparam addr_t DESC_BASE  = 16'h0100;
  localparam addr_t DECOY_BASE = 16'h0200;
  localparam addr_t SRC_BASE   = 16'h2000;
  localparam addr_t DST_BASE   = 16'h4000;   // One 16-word slot per entry
  localparam addr_t DECOY_DST  = 16'h6000;
  localparam int    SRC_WORDS  = 256;
  localparam int    MAX_LEN    = 12;

  logic       i_idma_backend;
  logic       reset_i;
  logic       reg_req;
  logic       reg_we;
  logic [2:0] reg_addr;
  word_t      reg_wdata;
  logic       reg_ready;
  word_t      reg_rdata;
  logic       mem_req;
  logic       mem_we;
  addr_t      mem_addr;
  word_t      mem_wdata;
  logic       mem_gnt;
  logic       mem_rvalid;
  word_t      mem_rdata;
  logic       irq;
  word_t      ref_mem [65536];
  int         n_checks = 0;
  int         n_errors = 0;
  int         exp_done = 0;
  int         exp_skip = 0;
  int         budget = 1000;   // Cycles allowed, grows with every chain built

  dma_desc_top DUT (
    .i_idma_backend (i_idma_backend),
    .reset_i        (reset_i),
    .reg_req_i      (reg_req),
    .reg_we_i       (reg_we),
    .reg_addr_i     (reg_addr),
    .reg_wdata_i    (reg_wdata),
    .reg_ready_o    (reg_ready),
    .reg_rdata_o    (reg_rdata),
    .mem_req_o      (mem_req),
    .mem_we_o       (mem_we),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_gnt_i      (mem_gnt),
    .mem_rvalid_i   (mem_rvalid),
    .mem_rdata_i    (mem_rdata),
    .irq_o          (irq)
  );

  tb_mem_model mem_model (
    .i_idma_backend (i_idma_backend),
    .reset_i        (reset_i),
    .mem_req_i      (mem_req),
    .mem_we_i       (mem_we),
    .mem_addr_i     (mem_addr),
    .mem_wdata_i    (mem_wdata),
    .mem_gnt_o      (mem_gnt),
    .mem_rvalid_o   (mem_rvalid),
    .mem_rdata_o    (mem_rdata)
  );

  initial begin
    i_idma_backend = 1'b0;
    forever #5 i_idma_backend = ~i_idma_backend;
  end

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic put_word(input addr_t a, input word_t d);
    mem_model.mem[a] = d;
    ref_mem[a]       = d;
  endtask

  task automatic init_memory();
    for (int a = 0; a < 65536; a++) begin
      put_word(addr_t'(a), {16'(a) ^ 16'hc3a5, 16'(a)});
    end
    for (int i = 0; i < SRC_WORDS; i++) put_word(addr_t'(SRC_BASE + i), $urandom());
  endtask

  // Mode 0 random lengths, 1 last entry zero-length, 2 all entries at full length
  task automatic build_chain(input addr_t base, input int n, input int mode);
    addr_t ent;
    addr_t src;
    addr_t dst;
    len_t  len;
    for (int i = 0; i < n; i++) begin
      ent = addr_t'(base + 4 * i);
      src = addr_t'(SRC_BASE + $urandom_range(SRC_WORDS - MAX_LEN, 0));
      dst = addr_t'(DST_BASE + 16 * i);
      case (mode)
        1:       len = (i == n - 1) ? '0 : len_t'($urandom_range(MAX_LEN, 1));
        2:       len = len_t'(MAX_LEN);
        default: len = len_t'($urandom_range(MAX_LEN, 0));
      endcase
      put_word(ent, word_t'(src));
      put_word(addr_t'(ent + 1), word_t'(dst));
      put_word(addr_t'(ent + 2), word_t'(len));
      put_word(addr_t'(ent + 3), (i == n - 1) ? '0 : word_t'(addr_t'(ent + 4)));
      for (int k = 0; k < int'(len); k++) begin
        ref_mem[addr_t'(dst + k)] = ref_mem[addr_t'(src + k)];
      end
      if (len == '0) exp_skip++;
      else exp_done++;
      budget += 200 * int'(len) + 100;
    end
  endtask

  // Called and returns 1 ns after a rising edge
  task automatic reg_access(input logic we, input logic [2:0] addr, input word_t wdata,
                            output word_t rdata);
    int waited;
    reg_req   = 1'b1;
    reg_we    = we;
    reg_addr  = addr;
    reg_wdata = wdata;
    waited    = 0;
    do begin
      @(posedge i_idma_backend);
      #1;
      waited++;
    end while (!reg_ready && waited < 10);
    if (!reg_ready) begin
      n_errors++;
      $display("register port gave no ready for offset %0d", addr);
    end
    rdata   = reg_rdata;
    reg_req = 1'b0;
    reg_we  = 1'b0;
  endtask

  task automatic compare_memory(input string name);
    int bad;
    bad = 0;
    for (int a = 0; a < 65536; a++) begin
      if (mem_model.mem[a] !== ref_mem[a]) begin
        bad++;
        $display("mismatch %s at %h: expected %h, actual %h", name, a[15:0], ref_mem[a],
                 mem_model.mem[a]);
      end
    end
    n_checks++;
    n_errors += bad;
  endtask

  task automatic finish_chain(input string name);
    word_t rd;
    while (!irq) begin
      @(posedge i_idma_backend);
      #1;
    end
    compare_memory(name);
    reg_access(1'b0, REG_DONE_CNT, '0, rd);
    check_word({name, " done count"}, word_t'(exp_done), rd);
    reg_access(1'b0, REG_SKIP_CNT, '0, rd);
    check_word({name, " skip count"}, word_t'(exp_skip), rd);
    reg_access(1'b0, REG_STATUS, '0, rd);
    check_word({name, " status before clear"}, 32'h2, rd);   // Idle, irq pending
    check_word({name, " irq before clear"}, 32'd1, word_t'(irq));
    reg_access(1'b1, REG_IRQ_CLR, '0, rd);
    check_word({name, " irq after clear"}, '0, word_t'(irq));
    reg_access(1'b0, REG_STATUS, '0, rd);
    check_word({name, " status after clear"}, '0, rd);
  endtask

  initial begin : main
    word_t rd;
    reset_i   = 1'b1;
    reg_req   = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    void'($urandom(78));
    init_memory();
    repeat (10) @(posedge i_idma_backend);
    #1;
    reset_i = 1'b0;
    check_word("memory request after reset", '0, word_t'(mem_req));
    check_word("register ready after reset", '0, word_t'(reg_ready));
    reg_access(1'b0, REG_DONE_CNT, '0, rd);
    check_word("done count after reset", '0, rd);
    reg_access(1'b0, REG_SKIP_CNT, '0, rd);
    check_word("skip count after reset", '0, rd);
    check_word("irq after reset", '0, word_t'(irq));

    for (int t = 0; t < 3; t++) begin
      build_chain(DESC_BASE, int'($urandom_range(6, 1)), 0);
      reg_access(1'b1, REG_HEAD, word_t'(DESC_BASE), rd);
      finish_chain($sformatf("random chain %0d", t));
    end

    build_chain(DESC_BASE, 3, 1);
    reg_access(1'b1, REG_HEAD, word_t'(DESC_BASE), rd);
    finish_chain("zero-length last entry");

    // Decoy entry that would copy 8 words if the head write were taken
    build_chain(DESC_BASE, 4, 2);
    put_word(DECOY_BASE, word_t'(SRC_BASE));
    put_word(addr_t'(DECOY_BASE + 1), word_t'(DECOY_DST));
    put_word(addr_t'(DECOY_BASE + 2), 32'd8);
    put_word(addr_t'(DECOY_BASE + 3), '0);
    reg_access(1'b1, REG_HEAD, word_t'(DESC_BASE), rd);
    reg_access(1'b0, REG_STATUS, '0, rd);
    n_checks++;
    if (!rd[STATUS_BUSY]) begin
      n_errors++;
      $display("status did not report busy while a chain was running");
    end
    reg_access(1'b1, REG_HEAD, word_t'(DECOY_BASE), rd);
    reg_access(1'b0, REG_HEAD, '0, rd);
    check_word("head after write while busy", word_t'(DESC_BASE), rd);
    finish_chain("head write while busy");

    build_chain(DESC_BASE, 8, 2);
    reg_access(1'b1, REG_HEAD, word_t'(DESC_BASE), rd);
    finish_chain("long chain");

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= budget) begin
      @(posedge i_idma_backend);
      cycles++;
    end
    $display("timeout: the DMA did not finish within %0d cycles", budget);
    $display("%0d checks, %0d errors", n_checks, n_errors + 1);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== verification/tb_mem_model.sv ====
/* Behavioural word memory for the DMA testbench. Grants in about 60 percent
   of cycles and answers each read 1 to 4 cycles after its grant, in order */
`timescale 1ns/100ps

module tb_mem_model import dma_desc_pkg::*; (
  input  logic  i_idma_backend,
  input  logic  reset_i,
  input  logic  mem_req_i,
  input  logic  mem_we_i,
  input  addr_t mem_addr_i,
  input  word_t mem_wdata_i,
  output logic  mem_gnt_o,
  output logic  mem_rvalid_o,
  output word_t mem_rdata_o
);

  word_t mem [65536];
  word_t rsp_data_q [$];
  int    rsp_due_q [$];
  int    cycle = 0;
  int    last_due = 0;

  initial begin
    mem_gnt_o    = 1'b0;
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
  end

  always @(posedge i_idma_backend) begin
    int due;
    cycle++;
    if (reset_i) begin
      rsp_data_q.delete();
      rsp_due_q.delete();
    end else if (mem_req_i && mem_gnt_o) begin
      if (mem_we_i) begin
        mem[mem_addr_i] = mem_wdata_i;
      end else begin
        due = cycle + int'($urandom_range(4, 1)) - 1;   // Latency 1 answers at the next edge
        if (due <= last_due) due = last_due + 1;        // Keeps responses in order
        last_due = due;
        rsp_data_q.push_back(mem[mem_addr_i]);
        rsp_due_q.push_back(due);
      end
    end
    #1;
    mem_gnt_o    = ($urandom_range(99, 0) < 60);
    mem_rvalid_o = 1'b0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
      mem_rvalid_o = 1'b1;
      mem_rdata_o  = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end
  end

endmodule

// ==== src/dma_desc_top.sv ====
/* Descriptor-chained DMA with a simple register port and one word memory port.
   The memory must grant in order and return one rvalid per read */
`timescale 1ns/100ps

module dma_desc_top import dma_desc_pkg::*; #(
  parameter int unsigned QueueDepth  = 2,
  parameter int unsigned BufferDepth = 4,
  parameter int unsigned MaxReads    = 4
) (
  input  logic       i_idma_backend,
  input  logic       reset_i,
  input  logic       reg_req_i,
  input  logic       reg_we_i,
  input  logic [2:0] reg_addr_i,
  input  word_t      reg_wdata_i,
  output logic       reg_ready_o,
  output word_t      reg_rdata_o,
  output logic       mem_req_o,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output word_t      mem_wdata_o,
  input  logic       mem_gnt_i,
  input  logic       mem_rvalid_i,
  input  word_t      mem_rdata_i,
  output logic       irq_o
);

  dma_mem_if  fetch_mem ();
  dma_mem_if  rd_mem ();
  dma_mem_if  wr_mem ();
  dma_desc_if desc_chan ();

  logic       start;
  addr_t      head;
  logic [1:0] skip;
  logic       fetch_busy;
  logic       done;
  logic       done_last;
  logic       engine_busy;

  dma_desc_regs i_regs (
    .i_idma_backend (i_idma_backend),
    .reset_i        (reset_i),
    .reg_req_i      (reg_req_i),
    .reg_we_i       (reg_we_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .skip_i         (skip),
    .done_i         (done),
    .done_last_i    (done_last),
    .fetch_busy_i   (fetch_busy),
    .engine_busy_i  (engine_busy),
    .reg_ready_o    (reg_ready_o),
    .reg_rdata_o    (reg_rdata_o),
    .start_o        (start),
    .head_o         (head),
    .irq_o          (irq_o)
  );

  dma_desc_fetch #(
    .QueueDepth (QueueDepth)
  ) i_fetch (
    .i_idma_backend (i_idma_backend),
    .reset_i        (reset_i),
    .start_i        (start),
    .head_i         (head),
    .mem            (fetch_mem.requester),
    .desc           (desc_chan.source),
    .skip_o         (skip),
    .busy_o         (fetch_busy)
  );

  dma_xfer_engine #(
    .QueueDepth  (QueueDepth),
    .BufferDepth (BufferDepth)
  ) i_engine (
    .i_idma_backend (i_idma_backend),
    .reset_i        (reset_i),
    .desc           (desc_chan.sink),
    .rd             (rd_mem.requester),
    .wr             (wr_mem.requester),
    .done_o         (done),
    .done_last_o    (done_last),
    .busy_o         (engine_busy)
  );

  dma_mem_arbiter #(
    .MaxReads (MaxReads)
  ) i_arbiter (
    .i_idma_backend (i_idma_backend),
    .reset_i        (reset_i),
    .fetch          (fetch_mem.arbiter),
    .rd             (rd_mem.arbiter),
    .wr             (wr_mem.arbiter),
    .mem_req_o      (mem_req_o),
    .mem_we_o       (mem_we_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .mem_rdata_i    (mem_rdata_i)
  );

endmodule

// ==== src/dma_mem_arbiter.sv ====
/* Round-robin merge of fetch, engine read and engine write onto one port.
   A waiting request keeps its slot until granted. Read owners queue in grant
   order, so the memory must answer reads in order */
`timescale 1ns/100ps

module dma_mem_arbiter import dma_desc_pkg::*; #(
  parameter int unsigned MaxReads = 4
) (
  input  logic       i_idma_backend,
  input  logic       reset_i,
  dma_mem_if.arbiter fetch,
  dma_mem_if.arbiter rd,
  dma_mem_if.arbiter wr,
  output logic       mem_req_o,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output word_t      mem_wdata_o,
  input  logic       mem_gnt_i,
  input  logic       mem_rvalid_i,
  input  word_t      mem_rdata_i
);

  localparam int unsigned NumReq  = 3;
  localparam int unsigned OwnPtrW = (MaxReads > 1) ? $clog2(MaxReads) : 1;
  localparam int unsigned OwnCntW = $clog2(MaxReads + 1);

  typedef logic [1:0] owner_t;

  logic [NumReq-1:0]  req;
  logic [NumReq-1:0]  we;
  logic [NumReq-1:0]  eligible;
  logic [NumReq-1:0]  gnt;
  logic [NumReq-1:0]  rvalid;
  addr_t              addr [NumReq];
  word_t              wdata [NumReq];
  owner_t             sel;
  owner_t             last_q;
  owner_t             held_sel_q;
  logic               held_q;
  logic               found;
  logic               push;
  owner_t             own_q [MaxReads];
  logic [OwnPtrW-1:0] own_wr_q;
  logic [OwnPtrW-1:0] own_rd_q;
  logic [OwnCntW-1:0] own_cnt_q;
  logic               own_full;

  assign req      = {wr.req, rd.req, fetch.req};
  assign we       = {wr.we, rd.we, fetch.we};
  assign addr     = '{fetch.addr, rd.addr, wr.addr};
  assign wdata    = '{fetch.wdata, rd.wdata, wr.wdata};
  assign own_full = (own_cnt_q == OwnCntW'(MaxReads));
  assign eligible = req & ~({NumReq{own_full}} & ~we);   // No new reads while owners are full

  always_comb begin : pick
    owner_t cand;
    sel   = last_q;
    found = 1'b0;
    for (int i = 1; i <= NumReq; i++) begin
      cand = owner_t'((int'(last_q) + i) % NumReq);
      if (!found && eligible[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
    end
    if (held_q) begin
      sel   = held_sel_q;
      found = 1'b1;
    end
  end

  assign mem_req_o   = found;
  assign mem_we_o    = we[sel];
  assign mem_addr_o  = addr[sel];
  assign mem_wdata_o = wdata[sel];
  assign push        = found & mem_gnt_i & ~we[sel];

  assign gnt    = (found & mem_gnt_i) ? (NumReq'(1) << sel) : '0;
  assign rvalid = mem_rvalid_i ? (NumReq'(1) << own_q[own_rd_q]) : '0;

  assign fetch.gnt    = gnt[0];
  assign rd.gnt       = gnt[1];
  assign wr.gnt       = gnt[2];
  assign fetch.rvalid = rvalid[0];
  assign rd.rvalid    = rvalid[1];
  assign wr.rvalid    = rvalid[2];
  assign fetch.rdata  = mem_rdata_i;
  assign rd.rdata     = mem_rdata_i;
  assign wr.rdata     = mem_rdata_i;

  always_ff @(posedge i_idma_backend) begin
    if (reset_i) begin
      last_q     <= owner_t'(NumReq - 1);   // Fetch goes first
      held_q     <= 1'b0;
      held_sel_q <= '0;
      own_wr_q   <= '0;
      own_rd_q   <= '0;
      own_cnt_q  <= '0;
    end else begin
      held_q     <= found & ~mem_gnt_i;
      held_sel_q <= sel;
      if (found & mem_gnt_i) last_q <= sel;
      if (push) own_wr_q <= (own_wr_q == OwnPtrW'(MaxReads - 1)) ? '0 : own_wr_q + 1'b1;
      if (mem_rvalid_i) begin
        own_rd_q <= (own_rd_q == OwnPtrW'(MaxReads - 1)) ? '0 : own_rd_q + 1'b1;
      end
      own_cnt_q <= own_cnt_q + OwnCntW'(push) - OwnCntW'(mem_rvalid_i);
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if (push) own_q[own_wr_q] <= sel;
  end

endmodule

// ==== src/dma_xfer_engine.sv ====
/* Copies one queued descriptor at a time, word by word.
   Reads of the next descriptor start only after the current one is popped.
   The queue has no ready and relies on the credits held by fetch */
`timescale 1ns/100ps

module dma_xfer_engine import dma_desc_pkg::*; #(
  parameter int unsigned QueueDepth  = 2,
  parameter int unsigned BufferDepth = 4
) (
  input  logic         i_idma_backend,
  input  logic         reset_i,
  dma_desc_if.sink     desc,
  dma_mem_if.requester rd,
  dma_mem_if.requester wr,
  output logic         done_o,
  output logic         done_last_o,
  output logic         busy_o
);

  localparam int unsigned QPtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned QCntW = $clog2(QueueDepth + 1);
  localparam int unsigned BPtrW = (BufferDepth > 1) ? $clog2(BufferDepth) : 1;
  localparam int unsigned BCntW = $clog2(BufferDepth + 1);

  desc_t            queue_q [QueueDepth];
  logic [QPtrW-1:0] q_wr_q;
  logic [QPtrW-1:0] q_rd_q;
  logic [QCntW-1:0] q_cnt_q;
  word_t            buf_q [BufferDepth];
  logic [BPtrW-1:0] b_wr_q;
  logic [BPtrW-1:0] b_rd_q;
  logic [BCntW-1:0] b_cnt_q;
  logic [BCntW-1:0] reserved_q;   // Buffered words plus reads in flight
  len_t             rd_idx_q;
  len_t             wr_idx_q;
  desc_t            head;
  logic             q_valid;
  logic             last_word;
  logic             pop;

  assign head      = queue_q[q_rd_q];
  assign q_valid   = (q_cnt_q != '0);
  assign last_word = (wr_idx_q == head.len - len_t'(1));
  assign pop       = wr.gnt & last_word;

  // Read sequencer
  assign rd.req   = q_valid & (rd_idx_q != head.len) & (reserved_q != BCntW'(BufferDepth));
  assign rd.we    = 1'b0;
  assign rd.addr  = head.src + rd_idx_q;
  assign rd.wdata = '0;

  // Write sequencer drains the buffer
  assign wr.req   = (b_cnt_q != '0);
  assign wr.we    = 1'b1;
  assign wr.addr  = head.dst + wr_idx_q;
  assign wr.wdata = buf_q[b_rd_q];

  assign desc.credit = done_o;
  assign busy_o      = q_valid;

  always_ff @(posedge i_idma_backend) begin
    if (reset_i) begin
      q_wr_q      <= '0;
      q_rd_q      <= '0;
      q_cnt_q     <= '0;
      b_wr_q      <= '0;
      b_rd_q      <= '0;
      b_cnt_q     <= '0;
      reserved_q  <= '0;
      rd_idx_q    <= '0;
      wr_idx_q    <= '0;
      done_o      <= 1'b0;
      done_last_o <= 1'b0;
    end else begin
      done_o      <= pop;
      done_last_o <= pop & head.last;
      if (desc.valid) q_wr_q <= (q_wr_q == QPtrW'(QueueDepth - 1)) ? '0 : q_wr_q + 1'b1;
      if (pop) q_rd_q <= (q_rd_q == QPtrW'(QueueDepth - 1)) ? '0 : q_rd_q + 1'b1;
      q_cnt_q <= q_cnt_q + QCntW'(desc.valid) - QCntW'(pop);
      if (rd.rvalid) b_wr_q <= (b_wr_q == BPtrW'(BufferDepth - 1)) ? '0 : b_wr_q + 1'b1;
      if (wr.gnt) b_rd_q <= (b_rd_q == BPtrW'(BufferDepth - 1)) ? '0 : b_rd_q + 1'b1;
      b_cnt_q    <= b_cnt_q + BCntW'(rd.rvalid) - BCntW'(wr.gnt);
      reserved_q <= reserved_q + BCntW'(rd.gnt) - BCntW'(wr.gnt);
      if (rd.gnt) rd_idx_q <= rd_idx_q + 1'b1;
      if (wr.gnt) wr_idx_q <= wr_idx_q + 1'b1;
      if (pop) begin
        rd_idx_q <= '0;
        wr_idx_q <= '0;
      end
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if (desc.valid) queue_q[q_wr_q] <= desc.desc;
    if (rd.rvalid) buf_q[b_wr_q] <= rd.rdata;
  end

endmodule

// ==== src/dma_desc_fetch.sv ====
/* Walks a descriptor chain, four reads per entry, all may be outstanding.
   Zero-length entries are skipped. Starts with QueueDepth credits,
   so it must match the engine's queue depth */
`timescale 1ns/100ps

module dma_desc_fetch import dma_desc_pkg::*; #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic         i_idma_backend,
  input  logic         reset_i,
  input  logic         start_i,
  input  addr_t        head_i,
  dma_mem_if.requester mem,
  dma_desc_if.source   desc,
  output logic [1:0]   skip_o,   // Bit 0 skip pulse, bit 1 entry was last
  output logic         busy_o
);

  localparam int unsigned CredW = $clog2(QueueDepth + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT,
    ST_HAND,
    ST_NEXT
  } state_e;

  state_e           state_q;
  logic [2:0]       req_cnt_q;
  logic [2:0]       rsp_cnt_q;
  logic [CredW-1:0] credit_q;
  addr_t            base_q;
  addr_t            src_q;
  addr_t            dst_q;
  len_t             len_q;
  addr_t            next_q;
  logic             zero_len;
  logic             send;

  assign zero_len = (len_q == '0);
  assign send     = (state_q == ST_HAND) & ~zero_len & (credit_q != '0);

  assign mem.req   = (state_q == ST_REQ);
  assign mem.we    = 1'b0;
  assign mem.addr  = base_q + addr_t'(req_cnt_q);
  assign mem.wdata = '0;

  assign desc.valid = send;
  assign desc.desc  = '{src: src_q, dst: dst_q, len: len_q, last: (next_q == '0)};

  assign skip_o = {next_q == '0, (state_q == ST_HAND) & zero_len};
  assign busy_o = (state_q != ST_IDLE);

  always_ff @(posedge i_idma_backend) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      req_cnt_q <= '0;
      rsp_cnt_q <= '0;
      credit_q  <= CredW'(QueueDepth);
    end else begin
      if (mem.rvalid) rsp_cnt_q <= rsp_cnt_q + 1'b1;
      case (state_q)
        ST_IDLE: if (start_i) state_q <= ST_REQ;
        ST_REQ: begin
          if (mem.gnt) begin
            req_cnt_q <= req_cnt_q + 1'b1;
            if (req_cnt_q == 3'(DESC_WORDS - 1)) state_q <= ST_WAIT;
          end
        end
        ST_WAIT: if (rsp_cnt_q == 3'(DESC_WORDS)) state_q <= ST_HAND;
        ST_HAND: if (zero_len | send) state_q <= ST_NEXT;   // Else wait for a credit
        ST_NEXT: begin
          req_cnt_q <= '0;
          rsp_cnt_q <= '0;
          state_q   <= (next_q == '0) ? ST_IDLE : ST_REQ;
        end
        default: state_q <= ST_IDLE;
      endcase
      case ({send, desc.credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if ((state_q == ST_IDLE) && start_i) begin
      base_q <= head_i;
    end else if (state_q == ST_NEXT) begin
      base_q <= next_q;
    end
    if (mem.rvalid) begin
      case (rsp_cnt_q[1:0])
        DESC_SRC:  src_q  <= mem.rdata[$bits(addr_t)-1:0];
        DESC_DST:  dst_q  <= mem.rdata[$bits(addr_t)-1:0];
        DESC_LEN:  len_q  <= mem.rdata[$bits(len_t)-1:0];
        DESC_NEXT: next_q <= mem.rdata[$bits(addr_t)-1:0];
        default:   src_q  <= src_q;
      endcase
    end
  end

endmodule

// ==== src/dma_desc_regs.sv ====
/* Register file of the DMA. One access per request, answered one cycle later.
   A head write while busy is dropped; irq stays set until written to REG_IRQ_CLR */
`timescale 1ns/100ps

module dma_desc_regs import dma_desc_pkg::*; (
  input  logic       i_idma_backend,
  input  logic       reset_i,
  input  logic       reg_req_i,
  input  logic       reg_we_i,
  input  logic [2:0] reg_addr_i,
  input  word_t      reg_wdata_i,
  input  logic [1:0] skip_i,        // Bit 0 skip pulse, bit 1 skipped entry was last
  input  logic       done_i,
  input  logic       done_last_i,
  input  logic       fetch_busy_i,
  input  logic       engine_busy_i,
  output logic       reg_ready_o,
  output word_t      reg_rdata_o,
  output logic       start_o,
  output addr_t      head_o,
  output logic       irq_o
);

  logic  access;
  logic  busy;
  logic  head_wr;
  logic  pend_last_q;
  word_t done_cnt_q;
  word_t skip_cnt_q;
  word_t status;

  assign access  = reg_req_i & ~reg_ready_o;   // Request is held through the ready cycle
  assign busy    = fetch_busy_i | engine_busy_i | start_o | pend_last_q;
  assign head_wr = access & reg_we_i & (reg_addr_i == REG_HEAD) & ~busy;

  always_comb begin
    status              = '0;
    status[STATUS_BUSY] = busy;
    status[STATUS_IRQ]  = irq_o;
  end

  always_ff @(posedge i_idma_backend) begin
    if (reset_i) begin
      reg_ready_o <= 1'b0;
      start_o     <= 1'b0;
      irq_o       <= 1'b0;
      pend_last_q <= 1'b0;
      done_cnt_q  <= '0;
      skip_cnt_q  <= '0;
    end else begin
      reg_ready_o <= access;
      start_o     <= head_wr;
      if (done_i) done_cnt_q <= done_cnt_q + 1'b1;
      if (skip_i[0]) skip_cnt_q <= skip_cnt_q + 1'b1;
      // A skipped last entry completes the chain once the engine drains
      if (skip_i[0] & skip_i[1]) begin
        pend_last_q <= 1'b1;
      end else if (pend_last_q & ~engine_busy_i) begin
        pend_last_q <= 1'b0;
      end
      if (access & reg_we_i & (reg_addr_i == REG_IRQ_CLR)) irq_o <= 1'b0;
      if ((done_i & done_last_i) | (pend_last_q & ~engine_busy_i)) irq_o <= 1'b1;
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if (head_wr) head_o <= reg_wdata_i[$bits(addr_t)-1:0];
    if (access & ~reg_we_i) begin
      case (reg_addr_i)
        REG_HEAD:     reg_rdata_o <= word_t'(head_o);
        REG_STATUS:   reg_rdata_o <= status;
        REG_DONE_CNT: reg_rdata_o <= done_cnt_q;
        REG_SKIP_CNT: reg_rdata_o <= skip_cnt_q;
        default:      reg_rdata_o <= '0;
      endcase
    end
  end

endmodule

// ==== src/dma_desc_if.sv ====
/* Descriptor hand-over from fetch to engine.
   No ready: the source may only send while it holds a credit */
`timescale 1ns/100ps

interface dma_desc_if import dma_desc_pkg::*; ();

  logic  valid;
  desc_t desc;
  logic  credit;   // One pulse per descriptor popped by the sink

  modport source (
    output valid,
    output desc,
    input  credit
  );

  modport sink (
    input  valid,
    input  desc,
    output credit
  );

endinterface

// ==== src/dma_mem_if.sv ====
/* Word memory port of one requester.
   Request fields stay steady until gnt; reads answer in grant order */
`timescale 1ns/100ps

interface dma_mem_if import dma_desc_pkg::*; ();

  logic  req;
  logic  we;
  addr_t addr;
  word_t wdata;
  logic  gnt;
  logic  rvalid;
  word_t rdata;

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata
  );

endinterface

// ==== src/dma_desc_pkg.sv ====
/* Shared types and register map of the descriptor DMA.
   Addresses and lengths count 32-bit words and are 16 bits wide.
   A descriptor is four words in memory: source, destination, length, next */
package dma_desc_pkg;

  typedef logic [31:0] word_t;
  typedef logic [15:0] addr_t;
  typedef logic [15:0] len_t;

  // Descriptor as handed from fetch to the engine
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
    logic  last;   // Next pointer was zero
  } desc_t;

  localparam int unsigned DESC_WORDS = 4;

  // Word position inside a descriptor entry
  localparam logic [1:0] DESC_SRC  = 2'd0;
  localparam logic [1:0] DESC_DST  = 2'd1;
  localparam logic [1:0] DESC_LEN  = 2'd2;
  localparam logic [1:0] DESC_NEXT = 2'd3;

  // Register word offsets
  localparam logic [2:0] REG_HEAD     = 3'd0;
  localparam logic [2:0] REG_STATUS   = 3'd1;
  localparam logic [2:0] REG_IRQ_CLR  = 3'd2;
  localparam logic [2:0] REG_DONE_CNT = 3'd3;
  localparam logic [2:0] REG_SKIP_CNT = 3'd4;

  localparam int unsigned STATUS_BUSY = 0;
  localparam int unsigned STATUS_IRQ  = 1;

endpackage
